//--- credit_link_top.sv
`timescale 1ns/1ps

module credit_link_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [link_pkg::FLIT_W-1:0] in_data,
	input  logic                        in_flush,
	output logic                        in_ready,
	input  logic                        out_pop,
	output logic                        out_valid,
	output logic [link_pkg::FLIT_W-1:0] out_data,
	output logic [1:0]                  out_level,
	output logic                        out_empty,
	output logic                        out_near_full
);

	import link_pkg::*;

	////////////////////////////////////////////////////////////
	// point-to-point link
	////////////////////////////////////////////////////////////

	link_op_e          link_op;
	logic [FLIT_W-1:0] link_data;
	logic              link_credit;

	// receiver to fifo bundle
	fifo_if u_fifo_if ();

	credit_sender u_sender (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_data     (in_data),
		.in_flush    (in_flush),
		.in_ready    (in_ready),
		.link_op     (link_op),
		.link_data   (link_data),
		.link_credit (link_credit)
	);

	credit_receiver u_receiver (
		.clk         (clk),
		.rst         (rst),
		.link_op     (link_op),
		.link_data   (link_data),
		.link_credit (link_credit),
		.out_pop     (out_pop),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.fifo        (u_fifo_if.fifo_user)
	);

	sync_fifo u_fifo (
		.clk  (clk),
		.rst  (rst),
		.fifo (u_fifo_if.fifo_owner)
	);

	// status straight from the fifo, empty is the registered flag
	assign out_level     = u_fifo_if.level;
	assign out_empty     = u_fifo_if.empty_r;
	assign out_near_full = u_fifo_if.near_full;

endmodule

//--- credit_receiver.sv
`timescale 1ns/1ps

module credit_receiver (
	input  logic                        clk,
	input  logic                        rst,
	input  link_pkg::link_op_e          link_op,
	input  logic [link_pkg::FLIT_W-1:0] link_data,
	output logic                        link_credit,
	input  logic                        out_pop,
	output logic                        out_valid,
	output logic [link_pkg::FLIT_W-1:0] out_data,
	fifo_if.fifo_user                   fifo
);

	import link_pkg::*;

	// decoded link opcode
	logic flush;

	// pop that really removes an entry this cycle
	logic pop_ok;

	// registered pop, drives both valid and credit
	logic pop_q;

	////////////////////////////////////////////////////////////
	// link to fifo
	////////////////////////////////////////////////////////////

	assign flush = (link_op == LINK_FLUSH);

	// write happens at the edge closing the data cycle
	assign fifo.push      = (link_op == LINK_DATA);
	assign fifo.push_data = link_data;
	assign fifo.clr       = flush;

	////////////////////////////////////////////////////////////
	// downstream pop
	////////////////////////////////////////////////////////////

	// no pop from an empty fifo and none while it is being cleared
	assign pop_ok   = out_pop & ~fifo.empty & ~flush;
	assign fifo.pop = pop_ok;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pop_q <= 1'b0;
		end else begin
			pop_q <= pop_ok;
		end
	end

	// ram read port is registered, data lines up with pop_q
	assign out_valid = pop_q;
	assign out_data  = fifo.pop_data;

	// each freed entry returns one credit
	assign link_credit = pop_q;

endmodule

//--- credit_sender.sv
`timescale 1ns/1ps

module credit_sender (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        in_valid,
	input  logic [link_pkg::FLIT_W-1:0] in_data,
	input  logic                        in_flush,
	output logic                        in_ready,
	output link_pkg::link_op_e          link_op,
	output logic [link_pkg::FLIT_W-1:0] link_data,
	input  logic                        link_credit
);

	import link_pkg::*;

	// credits held, 0 to DEPTH
	logic [CNT_W-1:0] credits;
	logic [CNT_W-1:0] credits_nxt;

	// handshake and usable credit return this cycle
	logic send;
	logic credit_in;

	////////////////////////////////////////////////////////////
	// upstream handshake
	////////////////////////////////////////////////////////////

	// flush wins over data, so no handshake while it is asserted
	assign in_ready = (credits != '0) & ~in_flush;
	assign send     = in_valid & in_ready;

	// credits that show up around a flush belong to cleared state
	assign credit_in = link_credit & (link_op != LINK_FLUSH);

	////////////////////////////////////////////////////////////
	// credit counter
	////////////////////////////////////////////////////////////

	always_comb begin
		credits_nxt = credits;
		if (send && !credit_in) begin
			credits_nxt = credits - CNT_W'(1);
		end else if (credit_in && !send) begin
			credits_nxt = credits + CNT_W'(1);
		end
	end

	// flush refills to DEPTH regardless of anything returned
	always_ff @(posedge clk) begin
		if (!rst) begin
			credits <= CNT_W'(DEPTH);
			link_op <= LINK_IDLE;
		end else if (in_flush) begin
			credits <= CNT_W'(DEPTH);
			link_op <= LINK_FLUSH;
		end else begin
			credits <= credits_nxt;
			link_op <= send ? LINK_DATA : LINK_IDLE;
		end
	end

	////////////////////////////////////////////////////////////
	// link payload
	////////////////////////////////////////////////////////////

	// only meaningful alongside LINK_DATA
	always_ff @(posedge clk) begin
		if (send) begin
			link_data <= in_data;
		end
	end

endmodule

//--- dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
	input  logic                         clk,
	input  logic                         wr_en,
	input  logic [link_pkg::ADDR_W-1:0]  wr_addr,
	input  logic [link_pkg::FLIT_W-1:0]  wr_data,
	input  logic                         rd_en,
	input  logic [link_pkg::ADDR_W-1:0]  rd_addr,
	output logic [link_pkg::FLIT_W-1:0]  rd_data
);

	import link_pkg::*;

	// storage array, one word per fifo entry
	logic [FLIT_W-1:0] mem [DEPTH];

	////////////////////////////////////////////////////////////
	// write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// registered read port
	////////////////////////////////////////////////////////////

	// same-edge read of the written address sees the old word
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- fifo_if.sv
`timescale 1ns/1ps

interface fifo_if;

	import link_pkg::*;

	// write side, driven by the fifo user
	logic              push;
	logic [FLIT_W-1:0] push_data;

	// read side and clear, driven by the fifo user
	logic              pop;
	logic              clr;

	// read data and status, driven by the fifo itself
	logic [FLIT_W-1:0] pop_data;
	logic              empty;
	logic              full;
	logic              empty_r;
	logic              full_r;
	logic              near_empty;
	logic              near_full;
	logic [1:0]        level;

	// receiver side view
	modport fifo_user (
		output push, push_data, pop, clr,
		input  pop_data, empty, full, empty_r, full_r,
		input  near_empty, near_full, level
	);

	// fifo side view
	modport fifo_owner (
		input  push, push_data, pop, clr,
		output pop_data, empty, full, empty_r, full_r,
		output near_empty, near_full, level
	);

endinterface

//--- link_pkg.sv
package link_pkg;

	////////////////////////////////////////////////////////////
	// flit and fifo geometry
	////////////////////////////////////////////////////////////

	// payload width of one flit
	localparam int FLIT_W = 72;

	// fifo address width and entry count
	localparam int ADDR_W = 2;
	localparam int DEPTH  = 4;

	// occupancy count needs one extra bit to hold DEPTH itself
	localparam int CNT_W = ADDR_W + 1;

	// near flags threshold
	// near_empty while count < NEAR_N
	// near_full while count >= DEPTH - NEAR_N + 1
	localparam int NEAR_N = 1;

	////////////////////////////////////////////////////////////
	// link opcodes
	////////////////////////////////////////////////////////////

	// one opcode per cycle on the link, idle when nothing is sent
	typedef enum logic [1:0] {
		LINK_IDLE  = 2'd0,
		LINK_DATA  = 2'd1,
		LINK_FLUSH = 2'd2
	} link_op_e;

endpackage

//--- link_vectors.txt
# op data level empty, data in hex (RAND: data is the step count in hex)
# a level or empty of -1 leaves that step to the reference model alone
IDLE  0                  0 1
PUSH  123456789abcdef012 1 0
POP   0                  0 1
PUSH  a1                 1 0
PUSH  a2                 2 0
PUSH  a3                 3 0
PUSH  a4                 3 0
PUSH  a5                 3 0
PUSH  a6                 3 0
POP   0                  3 0
PUSH  a7                 3 0
POP   0                  3 0
POP   0                  2 0
POP   0                  1 0
POP   0                  0 1
POP   0                  0 1
PUSH  b1                 1 0
PUSH  b2                 2 0
FLUSH 0                  0 1
POP   0                  0 1
PUSH  c1                 1 0
PUSH  c2                 2 0
PUSH  c3                 3 0
PUSH  c4                 3 0
POP   0                  3 0
BOTH  c5                 3 0
POP   0                  2 0
RAND  c8                 -1 -1
FLUSH 0                  0 1
PUSH  fedcba9876543210ff 1 0
POP   0                  0 1

//--- project.f
link_pkg.sv
fifo_if.sv
dual_port_ram.sv
sync_fifo.sv
credit_sender.sv
credit_receiver.sv
credit_link_top.sv
tb_clock_gen.sv
tb_credit_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the credit link testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found on PATH"
	exit 1
fi

verilator --binary --timing --top-module tb_credit_link -f project.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

output=$(./obj_dir/Vtb_credit_link)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

# the run passes only if the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
	input logic clk,
	input logic rst,
	fifo_if.fifo_owner fifo
);

	import link_pkg::*;

	// pointers and their look-ahead values
	logic [ADDR_W-1:0] wp;
	logic [ADDR_W-1:0] wp_pl1;
	logic [ADDR_W-1:0] wp_pl2;
	logic [ADDR_W-1:0] rp;
	logic [ADDR_W-1:0] rp_pl1;

	// guard bits
	// gb marks wp == rp as full rather than empty
	// gb2 marks the count at DEPTH-1 or above
	logic gb;
	logic gb2;

	// occupancy
	logic [CNT_W-1:0] cnt;

	// qualified push and pop
	logic we;
	logic re;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	dual_port_ram u_ram (
		.clk     (clk),
		.wr_en   (we),
		.wr_addr (wp),
		.wr_data (fifo.push_data),
		.rd_en   (re),
		.rd_addr (rp),
		.rd_data (fifo.pop_data)
	);

	// push on full and pop on empty are dropped here
	assign we = fifo.push & ~fifo.full;
	assign re = fifo.pop & ~fifo.empty;

	////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////

	assign wp_pl1 = wp + ADDR_W'(1);
	assign wp_pl2 = wp + ADDR_W'(2);
	assign rp_pl1 = rp + ADDR_W'(1);

	always_ff @(posedge clk) begin
		if (!rst || fifo.clr) begin
			wp <= '0;
			rp <= '0;
		end else begin
			if (we) begin
				wp <= wp_pl1;
			end
			if (re) begin
				rp <= rp_pl1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// combinational full and empty
	////////////////////////////////////////////////////////////

	assign fifo.empty = (wp == rp) & ~gb;
	assign fifo.full  = (wp == rp) & gb;

	// set when a lone push closes the gap, cleared by a lone pop
	always_ff @(posedge clk) begin
		if (!rst || fifo.clr) begin
			gb <= 1'b0;
		end else if (we && !re && (wp_pl1 == rp)) begin
			gb <= 1'b1;
		end else if (re && !we) begin
			gb <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// registered full and empty
	////////////////////////////////////////////////////////////

	// set when a lone push reaches DEPTH-1 entries
	always_ff @(posedge clk) begin
		if (!rst || fifo.clr) begin
			gb2 <= 1'b0;
		end else if (we && !re && (wp_pl2 == rp)) begin
			gb2 <= 1'b1;
		end else if (re && !we && (wp != rp)) begin
			gb2 <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || fifo.clr) begin
			fifo.full_r  <= 1'b0;
			fifo.empty_r <= 1'b1;
		end else begin
			// last free slot taken
			if (we && !re && (wp_pl1 == rp) && gb2) begin
				fifo.full_r <= 1'b1;
			end else if (re && !we) begin
				fifo.full_r <= 1'b0;
			end
			// last entry drained
			if (we && !re) begin
				fifo.empty_r <= 1'b0;
			end else if (re && !we && (rp_pl1 == wp) && !gb2) begin
				fifo.empty_r <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// occupancy, near flags and level
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst || fifo.clr) begin
			cnt <= '0;
		end else if (we && !re) begin
			cnt <= cnt + CNT_W'(1);
		end else if (re && !we) begin
			cnt <= cnt - CNT_W'(1);
		end
	end

	assign fifo.near_empty = cnt < CNT_W'(NEAR_N);
	assign fifo.near_full  = cnt >= CNT_W'(DEPTH - NEAR_N + 1);

	// top bit of cnt only set when full, forces level to 3
	assign fifo.level = cnt[ADDR_W-1:ADDR_W-2] | {2{cnt[ADDR_W]}};

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	// free running clock, low at time zero
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// active low reset, released shortly after an edge like every other input
	initial begin
		rst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst = 1'b1;
	end

endmodule

//--- tb_credit_link.sv
`timescale 1ns/1ps

module tb_credit_link;

	import link_pkg::*;

	localparam int    PERIOD     = 20;
	localparam int    RST_CYCLES = 10;
	localparam int    NEAR_TH    = 1;
	localparam int    LEVEL_MAX  = 3;
	localparam int    SEED       = 78482;
	localparam int    MAX_VEC    = 64;
	localparam int    STEP_LIMIT = 20;
	localparam string VEC_FILE   = "link_vectors.txt";

	// vector opcodes
	localparam int OP_PUSH  = 0;
	localparam int OP_POP   = 1;
	localparam int OP_BOTH  = 2;
	localparam int OP_FLUSH = 3;
	localparam int OP_IDLE  = 4;
	localparam int OP_RAND  = 5;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic [FLIT_W-1:0] in_data;
	logic              in_flush;
	logic              in_ready;
	logic              out_pop;
	logic              out_valid;
	logic [FLIT_W-1:0] out_data;
	logic [1:0]        out_level;
	logic              out_empty;
	logic              out_near_full;

	// vector table
	int                vec_op   [MAX_VEC];
	logic [FLIT_W-1:0] vec_data [MAX_VEC];
	int                vec_lvl  [MAX_VEC];
	int                vec_emp  [MAX_VEC];
	int                n_vec;
	int                total_steps;
	bit                load_done;

	// reference model holds the flits in order plus the sender's credits
	logic [FLIT_W-1:0] model_q[$];
	int                model_credits;

	int errors;
	int checks;

	tb_clock_gen #(.PERIOD(PERIOD), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	credit_link_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.in_data       (in_data),
		.in_flush      (in_flush),
		.in_ready      (in_ready),
		.out_pop       (out_pop),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_level     (out_level),
		.out_empty     (out_empty),
		.out_near_full (out_near_full)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [FLIT_W-1:0] expected,
			input logic [FLIT_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic int op_code(input logic [63:0] tok);
		case (tok)
			64'("PUSH"):  return OP_PUSH;
			64'("POP"):   return OP_POP;
			64'("BOTH"):  return OP_BOTH;
			64'("FLUSH"): return OP_FLUSH;
			64'("IDLE"):  return OP_IDLE;
			64'("RAND"):  return OP_RAND;
			default:      return -1;
		endcase
	endfunction

	// reads one entry per line and skips lines opening with #
	task automatic load_vectors();
		int                fd;
		int                r;
		int                code;
		int                lvl;
		int                emp;
		bit                done;
		logic [63:0]       tok;
		logic [8*256-1:0]  skip;
		logic [FLIT_W-1:0] d;
		done = 1'b0;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("could not open vector file %s", VEC_FILE);
			done = 1'b1;
		end
		while (!done) begin
			tok = '0;
			r = $fscanf(fd, "%s", tok);
			if (r != 1) begin
				done = 1'b1;
			end else if (tok == 64'("#")) begin
				r = $fgets(skip, fd);
			end else begin
				r = $fscanf(fd, "%h %d %d", d, lvl, emp);
				code = op_code(tok);
				if (r != 3 || code < 0 || n_vec >= MAX_VEC) begin
					errors++;
					$display("vector entry %0d in %s could not be read", n_vec, VEC_FILE);
				end else begin
					vec_op[n_vec]   = code;
					vec_data[n_vec] = d;
					vec_lvl[n_vec]  = lvl;
					vec_emp[n_vec]  = emp;
					// a random line expands into its step count
					total_steps += (code == OP_RAND) ? int'(d[15:0]) : 1;
					n_vec++;
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// one step drives a cycle and lets link and credits settle
	////////////////////////////////////////////////////////////

	task automatic run_step(input string label, input bit push_req, input bit pop_req,
			input bit flush_req, input logic [FLIT_W-1:0] data,
			input int exp_level, input int exp_empty);
		bit                exp_ready;
		bit                push_acc;
		bit                pop_acc;
		int                cnt;
		int                lvl_m;
		logic [FLIT_W-1:0] exp_data;
		exp_data = '0;
		@(posedge clk);
		#2;
		in_valid = push_req;
		in_data  = data;
		out_pop  = pop_req;
		in_flush = flush_req;
		// ready needs a credit and flush takes the cycle
		@(negedge clk);
		exp_ready = (model_credits != 0) && !flush_req;
		check_value({label, " in_ready"}, FLIT_W'(exp_ready), FLIT_W'(in_ready));
		push_acc = push_req && exp_ready;
		pop_acc  = pop_req && !flush_req && (model_q.size() != 0);
		// pop sees only entries stored before this push lands
		if (pop_acc) begin
			exp_data = model_q.pop_front();
			model_credits++;
		end
		if (push_req && in_ready && model_q.size() >= DEPTH) begin
			errors++;
			$display("%s: handshake accepted with no free fifo entry", label);
		end
		if (push_acc) begin
			model_q.push_back(data);
			model_credits--;
		end
		if (flush_req) begin
			model_q.delete();
			model_credits = DEPTH;
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		out_pop  = 1'b0;
		in_flush = 1'b0;
		// valid one cycle after the accepted pop
		@(negedge clk);
		check_value({label, " out_valid"}, FLIT_W'(pop_acc), FLIT_W'(out_valid));
		if (pop_acc) begin
			check_value({label, " out_data"}, exp_data, out_data);
		end
		@(posedge clk);
		@(negedge clk);
		cnt   = model_q.size();
		lvl_m = (cnt >= LEVEL_MAX) ? LEVEL_MAX : cnt;
		check_value({label, " level"}, FLIT_W'(lvl_m), FLIT_W'(out_level));
		check_value({label, " empty"}, FLIT_W'(cnt == 0), FLIT_W'(out_empty));
		check_value({label, " near_full"}, FLIT_W'(cnt >= DEPTH - NEAR_TH + 1),
			FLIT_W'(out_near_full));
		if (exp_level >= 0) begin
			check_value({label, " vector level"}, FLIT_W'(exp_level), FLIT_W'(out_level));
		end
		if (exp_empty >= 0) begin
			check_value({label, " vector empty"}, FLIT_W'(exp_empty), FLIT_W'(out_empty));
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int                i;
		int                k;
		int unsigned       r;
		logic [FLIT_W-1:0] rand_data;
		string             label;
		in_valid      = 1'b0;
		in_data       = '0;
		in_flush      = 1'b0;
		out_pop       = 1'b0;
		errors        = 0;
		checks        = 0;
		n_vec         = 0;
		total_steps   = 0;
		model_credits = DEPTH;
		void'($urandom(SEED));
		load_vectors();
		load_done = 1'b1;
		wait (rst === 1'b1);
		for (i = 0; i < n_vec; i++) begin
			label = $sformatf("vector %0d", i);
			case (vec_op[i])
				OP_PUSH:  run_step(label, 1'b1, 1'b0, 1'b0, vec_data[i], vec_lvl[i], vec_emp[i]);
				OP_POP:   run_step(label, 1'b0, 1'b1, 1'b0, '0, vec_lvl[i], vec_emp[i]);
				OP_BOTH:  run_step(label, 1'b1, 1'b1, 1'b0, vec_data[i], vec_lvl[i], vec_emp[i]);
				OP_FLUSH: run_step(label, 1'b0, 1'b0, 1'b1, '0, vec_lvl[i], vec_emp[i]);
				OP_IDLE:  run_step(label, 1'b0, 1'b0, 1'b0, '0, vec_lvl[i], vec_emp[i]);
				default: begin
					// random push and pop with the model alone predicting the result
					for (k = 0; k < int'(vec_data[i][15:0]); k++) begin
						r = $urandom();
						rand_data = {$urandom(), $urandom(), r[31:24]};
						run_step($sformatf("vector %0d rand %0d", i, k), r[0], r[1], 1'b0,
							rand_data, -1, -1);
					end
				end
			endcase
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog sized from the number of steps in the vector file
	initial begin
		wait (load_done);
		repeat (RST_CYCLES + STEP_LIMIT * (total_steps + 1)) @(posedge clk);
		$display("watchdog expired before the vector run completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
